//--- verilog/tetris_config.svh
`ifndef TETRIS_CONFIG_SVH
`define TETRIS_CONFIG_SVH

// Playfield size, row 0 at the top
`define BOARD_ROWS 22
`define BOARD_COLS 10

// Tetromino set I, O, T, S, Z, J, L
`define SHAPE_COUNT 7

// Left column of the 4x4 box when a piece appears
`define SPAWN_COL 3

// Cleared-line counter width
`define LINE_CNT_W 16

`endif

//--- verilog/tetris_pkg.sv
`include "tetris_config.svh"

package tetris_pkg;

    // Occupancy grid, indexed [row][col]
    typedef logic [`BOARD_ROWS-1:0][`BOARD_COLS-1:0] board_t;

    // 4x4 cell mask, bit r*4+c is cell (r, c) of the box
    typedef logic [15:0] mask_t;

    typedef struct packed {
        logic [2:0] shape;
        logic [4:0] row;   // Top of the 4x4 box
        logic [3:0] col;   // Left of the 4x4 box
    } piece_t;

    typedef struct packed {
        logic left;
        logic right;
    } move_t;

    // Spawn orientation only, every shape touches box row 0 and box col 0
    function automatic mask_t shape_mask(logic [2:0] shape);
        mask_t m;
        case (shape)
            3'd0:    m = 16'h000F;  // I
            3'd1:    m = 16'h0033;  // O
            3'd2:    m = 16'h0072;  // T
            3'd3:    m = 16'h0036;  // S
            3'd4:    m = 16'h0063;  // Z
            3'd5:    m = 16'h0071;  // J
            3'd6:    m = 16'h0074;  // L
            default: m = 16'h0000;
        endcase
        return m;
    endfunction

endpackage

//--- verilog/piece_spawner.sv
`include "tetris_config.svh"

module piece_spawner import tetris_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    output logic   spawn_req,
    output piece_t spawn_piece,
    input  logic   spawn_ack
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT
    } spawn_state_t;

    spawn_state_t state;
    logic [2:0]   shape_q;
    logic [2:0]   shape_next;

    // Fixed cycle through the seven shapes
    assign shape_next = (shape_q == 3'(`SHAPE_COUNT - 1)) ? 3'd0 : shape_q + 3'd1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= S_IDLE;
            shape_q <= 3'd0;
        end else begin
            case (state)
                S_IDLE: state <= S_REQ;  // First offer right after reset
                S_REQ: begin
                    if (spawn_ack) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    // Full handshake done once ack falls
                    if (!spawn_ack) begin
                        shape_q <= shape_next;
                        state   <= S_REQ;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign spawn_req = (state == S_REQ);

    // Offer stays stable while the request is up
    always_comb begin
        spawn_piece       = '0;
        spawn_piece.shape = shape_q;
        spawn_piece.row   = 5'd0;
        spawn_piece.col   = 4'(`SPAWN_COL);
    end

endmodule

//--- verilog/fall_engine.sv
`include "tetris_config.svh"

module fall_engine import tetris_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   drop_tick,
    input  move_t  move,
    input  logic   spawn_req,
    input  piece_t spawn_piece,
    output logic   spawn_ack,
    input  board_t grid,
    output logic   land_req,
    output piece_t land_piece,
    input  logic   land_ack,
    output piece_t active_piece,
    output logic   active_valid,
    output logic   game_over
);

    typedef enum logic [1:0] {
        SPAWN,
        FALLING,
        LAND,
        OVER
    } fall_state_t;

    fall_state_t state;
    piece_t      piece_q;      // Active piece position
    piece_t      shifted;
    piece_t      after_shift;
    piece_t      dropped;
    logic        drop_fits;
    logic        spawn_fits;
    logic        spawn_take;
    logic        tick_now;

    // True when every mask cell is on the board and clear of stored cells
    function automatic logic fits(piece_t p, board_t g);
        mask_t      m;
        logic [5:0] rr;
        logic [4:0] cc;
        logic       ok;
        int         r;
        int         c;
        m  = shape_mask(p.shape);
        ok = 1'b1;
        for (r = 0; r < 4; r++) begin
            for (c = 0; c < 4; c++) begin
                rr = {1'b0, p.row} + 6'(r);
                cc = {1'b0, p.col} + 5'(c);  // Col 15 after a left shift from 0 lands off board
                if (m[r*4+c]) begin
                    if (rr >= 6'(`BOARD_ROWS) || cc >= 5'(`BOARD_COLS)) begin
                        ok = 1'b0;
                    end else if (g[rr[4:0]][cc[3:0]]) begin
                        ok = 1'b0;
                    end
                end
            end
        end
        return ok;
    endfunction

    // Shift first, then one row down
    always_comb begin
        shifted = piece_q;
        if (move.left && !move.right) begin
            shifted.col = piece_q.col - 4'd1;
        end else if (move.right && !move.left) begin
            shifted.col = piece_q.col + 4'd1;
        end
        after_shift = fits(shifted, grid) ? shifted : piece_q;  // Blocked shift keeps column
        dropped     = after_shift;
        dropped.row = after_shift.row + 5'd1;
        drop_fits   = fits(dropped, grid);
        spawn_fits  = fits(spawn_piece, grid);
    end

    assign spawn_take = (state == SPAWN) && spawn_req && !spawn_ack;
    assign tick_now   = (state == FALLING) && drop_tick;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= SPAWN;
            spawn_ack <= 1'b0;
            land_req  <= 1'b0;
            game_over <= 1'b0;
        end else begin
            if (spawn_ack && !spawn_req) begin
                spawn_ack <= 1'b0;
            end
            case (state)
                SPAWN: begin
                    if (spawn_take) begin
                        spawn_ack <= 1'b1;
                        if (spawn_fits) begin
                            state <= FALLING;
                        end else begin
                            game_over <= 1'b1;  // Spawn overlaps the stack
                            state     <= OVER;
                        end
                    end
                end
                FALLING: begin
                    if (tick_now && !drop_fits) begin
                        land_req <= 1'b1;
                        state    <= LAND;
                    end
                end
                LAND: begin
                    if (land_req && land_ack) begin
                        land_req <= 1'b0;
                    end else if (!land_req && !land_ack) begin
                        state <= SPAWN;  // Grid is final by now
                    end
                end
                OVER: state <= OVER;  // Held until reset
                default: state <= SPAWN;
            endcase
        end
    end

    // Position register held stable through LAND for the board store
    always_ff @(posedge clk) begin
        if (spawn_take) begin
            piece_q <= spawn_piece;
        end else if (tick_now) begin
            piece_q <= drop_fits ? dropped : after_shift;
        end
    end

    assign active_piece = piece_q;
    assign land_piece   = piece_q;
    assign active_valid = (state == FALLING);

endmodule

//--- verilog/board_store.sv
`include "tetris_config.svh"

module board_store import tetris_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   land_req,
    input  piece_t                 land_piece,
    output logic                   land_ack,
    input  piece_t                 active_piece,
    input  logic                   active_valid,
    output board_t                 grid,
    output board_t                 display,
    output logic [`LINE_CNT_W-1:0] line_count
);

    typedef enum logic [1:0] {
        IDLE,
        CLEAR,
        ACK
    } store_state_t;

    store_state_t state;
    board_t       cleared;    // Grid with full rows removed
    board_t       overlay;
    logic [4:0]   full_rows;

    // Piece cells drawn onto an empty board
    function automatic board_t place(piece_t p);
        board_t     b;
        mask_t      m;
        logic [5:0] rr;
        logic [4:0] cc;
        int         r;
        int         c;
        b = '0;
        m = shape_mask(p.shape);
        for (r = 0; r < 4; r++) begin
            for (c = 0; c < 4; c++) begin
                rr = {1'b0, p.row} + 6'(r);
                cc = {1'b0, p.col} + 5'(c);
                if (m[r*4+c] && rr < 6'(`BOARD_ROWS) && cc < 5'(`BOARD_COLS)) begin
                    b[rr[4:0]][cc[3:0]] = 1'b1;
                end
            end
        end
        return b;
    endfunction

    // Walk up from the floor, copying only rows that are not full
    always_comb begin : compact
        int r;
        int w;
        cleared   = '0;
        full_rows = 5'd0;
        w         = `BOARD_ROWS - 1;
        for (r = `BOARD_ROWS - 1; r >= 0; r--) begin
            if (&grid[r]) begin
                full_rows = full_rows + 5'd1;
            end else begin
                cleared[w] = grid[r];
                w          = w - 1;
            end
        end
    end

    assign overlay = active_valid ? place(active_piece) : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= IDLE;
            grid       <= '0;
            land_ack   <= 1'b0;
            line_count <= '0;
            display    <= '0;
        end else begin
            display <= grid | overlay;
            case (state)
                IDLE: begin
                    if (land_req && !land_ack) begin
                        grid  <= grid | place(land_piece);  // Merge
                        state <= CLEAR;
                    end
                end
                CLEAR: begin
                    grid       <= cleared;
                    line_count <= line_count + `LINE_CNT_W'(full_rows);
                    land_ack   <= 1'b1;
                    state      <= ACK;
                end
                ACK: begin
                    if (!land_req) begin
                        land_ack <= 1'b0;
                        state    <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- verilog/tetris_core.sv
`include "tetris_config.svh"

module tetris_core import tetris_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   drop_tick,   // One-cycle enable in clk domain
    input  move_t                  move,
    output board_t                 display,
    output logic [`LINE_CNT_W-1:0] line_count,
    output logic                   game_over
);

    // Spawn handshake
    logic   spawn_req;
    logic   spawn_ack;
    piece_t spawn_piece;

    // Land handshake
    logic   land_req;
    logic   land_ack;
    piece_t land_piece;

    // Stored grid back to the fall engine, active piece forward for display
    board_t grid;
    piece_t active_piece;
    logic   active_valid;

    piece_spawner u_spawner (
        .clk         (clk),
        .reset       (reset),
        .spawn_req   (spawn_req),
        .spawn_piece (spawn_piece),
        .spawn_ack   (spawn_ack)
    );

    fall_engine u_fall (
        .clk          (clk),
        .reset        (reset),
        .drop_tick    (drop_tick),
        .move         (move),
        .spawn_req    (spawn_req),
        .spawn_piece  (spawn_piece),
        .spawn_ack    (spawn_ack),
        .grid         (grid),
        .land_req     (land_req),
        .land_piece   (land_piece),
        .land_ack     (land_ack),
        .active_piece (active_piece),
        .active_valid (active_valid),
        .game_over    (game_over)
    );

    board_store u_store (
        .clk          (clk),
        .reset        (reset),
        .land_req     (land_req),
        .land_piece   (land_piece),
        .land_ack     (land_ack),
        .active_piece (active_piece),
        .active_valid (active_valid),
        .grid         (grid),
        .display      (display),
        .line_count   (line_count)
    );

endmodule

//--- dv/tetris_ref_model.svh
`ifndef TETRIS_REF_MODEL_SVH
`define TETRIS_REF_MODEL_SVH

// Game model, stepped once per drop tick
board_t m_grid;
int     m_shape;
int     m_row;
int     m_col;
int     m_lines;
int     m_pieces;   // Landed since reset
bit     m_over;

// Four (row, col) cells per shape inside its 4x4 box, spawn orientation
function automatic logic [15:0] shape_cells(int s);
    logic [15:0] lst;
    case (s)
        0:       lst = {2'd0, 2'd0, 2'd0, 2'd1, 2'd0, 2'd2, 2'd0, 2'd3};  // I
        1:       lst = {2'd0, 2'd0, 2'd0, 2'd1, 2'd1, 2'd0, 2'd1, 2'd1};  // O
        2:       lst = {2'd0, 2'd1, 2'd1, 2'd0, 2'd1, 2'd1, 2'd1, 2'd2};  // T
        3:       lst = {2'd0, 2'd1, 2'd0, 2'd2, 2'd1, 2'd0, 2'd1, 2'd1};  // S
        4:       lst = {2'd0, 2'd0, 2'd0, 2'd1, 2'd1, 2'd1, 2'd1, 2'd2};  // Z
        5:       lst = {2'd0, 2'd0, 2'd1, 2'd0, 2'd1, 2'd1, 2'd1, 2'd2};  // J
        default: lst = {2'd0, 2'd2, 2'd1, 2'd0, 2'd1, 2'd1, 2'd1, 2'd2};  // L
    endcase
    return lst;
endfunction

function automatic int cell_row(int s, int k);
    logic [15:0] lst;
    lst = shape_cells(s);
    return int'(lst[15-4*k -: 2]);
endfunction

function automatic int cell_col(int s, int k);
    logic [15:0] lst;
    lst = shape_cells(s);
    return int'(lst[13-4*k -: 2]);
endfunction

function automatic bit piece_fits(int s, int row, int col);
    int r;
    int c;
    int k;
    bit ok;
    ok = 1'b1;
    for (k = 0; k < 4; k++) begin
        r = row + cell_row(s, k);
        c = col + cell_col(s, k);
        if (r < 0 || r >= `BOARD_ROWS || c < 0 || c >= `BOARD_COLS) begin
            ok = 1'b0;
        end else if (m_grid[r][c]) begin
            ok = 1'b0;
        end
    end
    return ok;
endfunction

function automatic void model_spawn();
    m_row = 0;
    m_col = `SPAWN_COL;
    if (!piece_fits(m_shape, m_row, m_col)) begin
        m_over = 1'b1;  // Spawn overlaps the stack
    end
endfunction

// Merge, drop full rows, then bring in the next shape
function automatic void model_land();
    board_t kept;
    int     k;
    int     r;
    int     w;
    for (k = 0; k < 4; k++) begin
        m_grid[m_row + cell_row(m_shape, k)][m_col + cell_col(m_shape, k)] = 1'b1;
    end
    kept = '0;
    w    = `BOARD_ROWS - 1;
    for (r = `BOARD_ROWS - 1; r >= 0; r--) begin
        if (&m_grid[r]) begin
            m_lines++;
        end else begin
            kept[w] = m_grid[r];
            w--;
        end
    end
    m_grid   = kept;
    m_pieces++;
    m_shape  = (m_shape + 1) % `SHAPE_COUNT;
    model_spawn();
endfunction

function automatic void model_tick(move_t mv);
    int nc;
    if (!m_over) begin
        nc = m_col;
        if (mv.left && !mv.right) begin
            nc = m_col - 1;
        end else if (mv.right && !mv.left) begin
            nc = m_col + 1;
        end
        if (piece_fits(m_shape, m_row, nc)) begin
            m_col = nc;
        end
        if (piece_fits(m_shape, m_row + 1, m_col)) begin
            m_row++;
        end else begin
            model_land();
        end
    end
endfunction

function automatic board_t model_display();
    board_t b;
    int     k;
    b = m_grid;
    if (!m_over) begin
        for (k = 0; k < 4; k++) begin
            b[m_row + cell_row(m_shape, k)][m_col + cell_col(m_shape, k)] = 1'b1;
        end
    end
    return b;
endfunction

function automatic void model_reset();
    m_grid   = '0;
    m_shape  = 0;
    m_lines  = 0;
    m_pieces = 0;
    m_over   = 1'b0;
    model_spawn();
endfunction

`endif

//--- dv/tb_tetris.sv
`include "tetris_config.svh"

module tb_tetris import tetris_pkg::*; ();

    localparam int TICKS_FALL   = 80;
    localparam int TICKS_SHIFT  = 120;
    localparam int TICKS_GUIDED = 160;   // Upper bound, stops after seven landings
    localparam int TICKS_LONG   = 4000;  // Upper bound, stops at game over
    localparam int TICKS_AFTER  = 5;
    localparam int TICKS_TOTAL  = TICKS_FALL + TICKS_SHIFT + TICKS_GUIDED
                                  + TICKS_LONG + TICKS_AFTER;
    localparam int SETTLE       = 14;    // Cycles from last tick to check

    logic                   clk;
    logic                   reset;
    logic                   drop_tick;
    move_t                  move;
    board_t                 display;
    logic [`LINE_CNT_W-1:0] line_count;
    logic                   game_over;

    logic [15:0] lfsr;
    board_t      exp_board;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int          i;

    `include "tetris_ref_model.svh"

    tetris_core dut0 (
        .clk        (clk),
        .reset      (reset),
        .drop_tick  (drop_tick),
        .move       (move),
        .display    (display),
        .line_count (line_count),
        .game_over  (game_over)
    );

    always #2 clk = ~clk;

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic take_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic int take_bits(int n);
        int v;
        int k;
        v = 0;
        for (k = 0; k < n; k++) begin
            v = (v << 1) | int'(take_bit());
        end
        return v;
    endfunction

    function automatic move_t random_move();
        move_t mv;
        mv.left  = take_bit();
        mv.right = take_bit();
        return mv;
    endfunction

    // Steer the current shape toward its slot in the bottom-row fill
    function automatic move_t guided_move();
        move_t mv;
        int    target;
        case (m_shape)
            5:       target = 4;  // J
            6:       target = 7;  // L
            default: target = 0;  // Stacked over the I
        endcase
        mv.left  = (m_col > target);
        mv.right = (m_col < target);
        return mv;
    endfunction

    task automatic check_board(string name, board_t exp, board_t act);
        if (act !== exp) begin
            $display("ERROR %s: display expected %h actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_count(string name, logic [`LINE_CNT_W-1:0] exp,
                               logic [`LINE_CNT_W-1:0] act);
        if (act !== exp) begin
            $display("ERROR %s: line_count expected %0d actual %0d", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_over(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("ERROR %s: game_over expected %b actual %b", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        model_reset();
    endtask

    // Idle 12 to 27 cycles, then a one-cycle tick
    task automatic send_tick(move_t mv);
        int gap;
        gap = 12 + take_bits(4);
        repeat (gap) @(posedge clk);
        #1;
        drop_tick = 1'b1;
        move      = mv;
        @(posedge clk);
        #1;
        drop_tick = 1'b0;
        move      = '0;
        model_tick(mv);
    endtask

    task automatic settle_and_check(string name);
        repeat (SETTLE) @(posedge clk);
        #1;
        check_board(name, model_display(), display);
        check_count(name, `LINE_CNT_W'(m_lines), line_count);
        check_over(name, m_over, game_over);
    endtask

    task automatic finish_test(string name);
        tests_run++;
        errors += test_errors;
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        repeat (TICKS_TOTAL * 30 + 2000) @(posedge clk);
        $display("watchdog: run did not finish in the allowed time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        drop_tick    = 1'b0;
        move         = '0;
        lfsr         = 16'd3589;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;

        // I piece alone at row 0, cols 3 to 6
        apply_reset();
        repeat (SETTLE) @(posedge clk);
        #1;
        exp_board = '0;
        for (i = 3; i <= 6; i++) begin
            exp_board[0][i] = 1'b1;
        end
        check_board("reset", exp_board, display);
        check_count("reset", '0, line_count);
        check_over("reset", 1'b0, game_over);
        finish_test("reset");

        for (i = 0; i < TICKS_FALL; i++) begin
            send_tick('0);
        end
        settle_and_check("fall_stack");
        finish_test("fall_stack");

        apply_reset();
        for (i = 0; i < TICKS_SHIFT; i++) begin
            send_tick(random_move());
        end
        settle_and_check("random_shift");
        finish_test("random_shift");

        apply_reset();
        for (i = 0; i < TICKS_GUIDED && m_pieces < `SHAPE_COUNT; i++) begin
            send_tick(guided_move());
        end
        if (m_lines != 1) begin
            $display("guided_clear: the guided fill did not remove exactly one row");
            test_errors++;
        end
        settle_and_check("guided_clear");
        finish_test("guided_clear");

        for (i = 0; i < TICKS_LONG && !m_over; i++) begin
            send_tick(random_move());
        end
        if (!m_over) begin
            $display("game_over: the stack never reached the spawn area");
            test_errors++;
        end
        for (i = 0; i < TICKS_AFTER; i++) begin
            send_tick(random_move());  // Ignored once the game has ended
        end
        settle_and_check("game_over");
        finish_test("game_over");

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+verilog
+incdir+dv
verilog/tetris_pkg.sv
verilog/piece_spawner.sv
verilog/fall_engine.sv
verilog/board_store.sv
verilog/tetris_core.sv
dv/tb_tetris.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, then run and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_tetris -f flist.f -o sim_tetris &&
    ./obj_dir/sim_tetris | tee /dev/stderr | grep -qx "TEST RESULT: PASS" &&
    echo "run_sim: simulation passed" ||
    { echo "run_sim: simulation failed"; exit 1; }
